/* vlog.f */
hdl/cpuPkg.sv
hdl/busMaster.sv
hdl/registerFile.sv
hdl/controlSequencer.sv
hdl/cpuSystem.sv
tb/tbMemory.sv
tb/tbCpuSystem.sv

/* Bender.yml */
package:
  name: cpu_system

sources:
  - files:
      - hdl/cpuPkg.sv
      - hdl/busMaster.sv
      - hdl/registerFile.sv
      - hdl/controlSequencer.sv
      - hdl/cpuSystem.sv
  - target: test
    files:
      - tb/tbMemory.sv
      - tb/tbCpuSystem.sv

/* tb/tbCpuSystem.sv */
`timescale 1ns/1ps

module tbCpuSystem
    import cpuPkg::*;
();

    typedef struct packed {
        logic  write;
        byte_t address;
        byte_t data;
    } transfer_t;

    logic      Clock = 1'b0;
    logic      Reset;
    wbMaster_t wbOut;
    wbSlave_t  wbIn;
    byte_t     image [256];
    transfer_t expected [256];
    string     expTest [256];
    int        expCount;
    int        xferIndex;
    logic      acked;
    transfer_t actual;

    always #50 Clock = ~Clock;                // 100 ns period

    cpuSystem i_cpuSystem (.Clock(Clock), .Reset(Reset), .wbOut(wbOut), .wbIn(wbIn));

    tbMemory i_memory (.Clock(Clock), .Reset(Reset), .wbOut(wbOut), .wbIn(wbIn),
                       .image(image));

    task automatic stopWithFailure(input string message);
        $display("%s", message);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    // ========================================
    // Program image and reference model
    // ========================================
    function automatic word_t encodeInstr(opcode_t op, regIndex_t r, byte_t field);
        return {op, r, field};
    endfunction

    task automatic placeInstr(input byte_t address, input word_t instr);
        image[address]        = instr[7:0];   // Low byte at PC
        image[address + 8'd1] = instr[15:8];
    endtask

    task automatic addTransfer(input string name, input logic write, input byte_t address,
                               input byte_t data);
        expected[expCount] = {write, address, data};
        expTest[expCount]  = name;
        expCount++;
    endtask

    task automatic fillImage();
        for (int a = 0; a < 256; a++) begin
            image[a] = {a[3:0], a[7:4]} ^ 8'h3C;
        end
        placeInstr(8'h00, encodeInstr(OpMovl, 2'd1, 8'h34));
        placeInstr(8'h02, encodeInstr(OpMovsh, 2'd1, 8'h12));
        placeInstr(8'h04, encodeInstr(OpSta, 2'd1, 8'hA0));
        placeInstr(8'h06, encodeInstr(OpLdal, 2'd2, 8'hC0));   // Copy C0/C1 to B0/B1
        placeInstr(8'h08, encodeInstr(OpSta, 2'd2, 8'hB0));
        placeInstr(8'h0A, encodeInstr(OpMovl, 2'd0, 8'h03));
        placeInstr(8'h0C, encodeInstr(OpDec, 2'd0, 8'h00));    // Counter loop
        placeInstr(8'h0E, encodeInstr(OpBne, 2'd0, 8'h0C));
        placeInstr(8'h10, encodeInstr(OpBeq, 2'd0, 8'h14));    // Taken on Z from DEC
        placeInstr(8'h12, encodeInstr(OpInc, 2'd2, 8'h00));    // Skipped
        placeInstr(8'h14, encodeInstr(OpInc, 2'd3, 8'h00));
        placeInstr(8'h16, encodeInstr(OpBeq, 2'd0, 8'h30));    // Not taken
        placeInstr(8'h18, encodeInstr(OpBra, 2'd0, 8'h20));
        placeInstr(8'h20, encodeInstr(6'h3F, 2'd0, 8'h55));    // Unused opcode
        placeInstr(8'h22, encodeInstr(OpSta, 2'd3, 8'hB2));
        placeInstr(8'h24, encodeInstr(OpBra, 2'd0, 8'h24));    // Halt loop
    endtask

    task automatic buildExpected();
        byte_t     model [256];
        word_t     regs [4];
        byte_t     pc;
        byte_t     start;
        byte_t     f;
        regIndex_t r;
        word_t     instr;
        logic      z;
        logic      halted;
        string     fetchName;
        int        steps;
        model     = image;
        regs      = '{default: '0};
        pc        = ResetPc;
        z         = 1'b0;
        halted    = 1'b0;
        fetchName = "fetch order";
        steps     = 0;
        expCount  = 0;
        while (!halted && steps < 100) begin
            start = pc;
            addTransfer(fetchName, 1'b0, pc, model[pc]);
            addTransfer(fetchName, 1'b0, pc + 8'd1, model[pc + 8'd1]);
            instr     = {model[pc + 8'd1], model[pc]};
            pc        = pc + 8'd2;
            f         = instr[7:0];
            r         = instr[9:8];
            fetchName = "fetch order";
            case (instr[15:10])
                OpBra: begin
                    fetchName = "BRA";
                    halted    = (f == start);
                    pc        = f;
                end
                OpBne: begin
                    fetchName = "BNE";
                    if (!z) pc = f;
                end
                OpBeq: begin
                    fetchName = "BEQ";
                    if (z) pc = f;
                end
                OpInc: begin
                    regs[r] = regs[r] + 16'd1;
                    z       = (regs[r] == 16'h0000);
                end
                OpDec: begin
                    regs[r] = regs[r] - 16'd1;
                    z       = (regs[r] == 16'h0000);
                end
                OpMovl:  regs[r] = {8'h00, f};
                OpMovsh: regs[r] = {regs[r][7:0], f};
                OpLdal: begin
                    addTransfer("LDAL", 1'b0, f, model[f]);
                    addTransfer("LDAL", 1'b0, f + 8'd1, model[f + 8'd1]);
                    regs[r] = {model[f + 8'd1], model[f]};
                end
                OpSta: begin
                    addTransfer("STA", 1'b1, f, regs[r][7:0]);
                    addTransfer("STA", 1'b1, f + 8'd1, regs[r][15:8]);
                    model[f]        = regs[r][7:0];
                    model[f + 8'd1] = regs[r][15:8];
                end
                default: ;                    // No-op
            endcase
            steps++;
        end
    endtask

    // ========================================
    // Transfer checks
    // ========================================
    assign acked  = wbOut.stb && wbIn.ack;
    assign actual = {wbOut.we, wbOut.adr, wbOut.we ? wbOut.datW : wbIn.datR};

    always @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            xferIndex <= 0;
        end else if (acked) begin
            xferIndex <= xferIndex + 1;
        end
    end

    assert property (@(posedge Clock) disable iff (Reset) acked |-> xferIndex < expCount)
    else stopWithFailure($sformatf("Unexpected transfer beyond the %0d expected", expCount));

    assert property (@(posedge Clock) disable iff (Reset)
        acked |-> actual.write == expected[xferIndex].write)
    else stopWithFailure($sformatf("Fail %s direction expected %0b actual %0b",
        expTest[$sampled(xferIndex)], expected[$sampled(xferIndex)].write,
        $sampled(actual.write)));

    assert property (@(posedge Clock) disable iff (Reset)
        acked |-> actual.address == expected[xferIndex].address)
    else stopWithFailure($sformatf("Fail %s address expected %02h actual %02h",
        expTest[$sampled(xferIndex)], expected[$sampled(xferIndex)].address,
        $sampled(actual.address)));

    assert property (@(posedge Clock) disable iff (Reset)
        acked |-> actual.data == expected[xferIndex].data)
    else stopWithFailure($sformatf("Fail %s data expected %02h actual %02h",
        expTest[$sampled(xferIndex)], expected[$sampled(xferIndex)].data,
        $sampled(actual.data)));

    // Cycle must close right after its ack
    assert property (@(posedge Clock) disable iff (Reset) acked |=> !wbOut.stb)
    else stopWithFailure("Bus cycle stayed open after its ack, transfers overlap");

    assert property (@(posedge Clock) disable iff (Reset) wbOut.cyc == wbOut.stb)
    else stopWithFailure("Wishbone cyc and stb do not match");

    // ========================================
    // Stimulus, watchdog and result
    // ========================================
    initial begin
        Reset = 1'b1;
        fillImage();
        buildExpected();
        repeat (16) @(posedge Clock);
        Reset <= 1'b0;
        while (xferIndex != expCount) begin
            @(posedge Clock);
        end
        repeat (2) @(posedge Clock);          // Let the last overlap check settle
        $display("TEST PASSED");
        $finish;
    end

    initial begin
        wait (Reset === 1'b0);
        repeat (expCount * 40) @(posedge Clock);
        stopWithFailure($sformatf("Timeout, the program did not finish within %0d cycles",
                                  expCount * 40));
    end

endmodule

/* tb/tbMemory.sv */
`timescale 1ns/1ps

module tbMemory
    import cpuPkg::*;
(
    input  logic      Clock,
    input  logic      Reset,
    input  wbMaster_t wbOut,
    output wbSlave_t  wbIn,
    input  byte_t     image [256]
);

    byte_t      mem [256];
    wbSlave_t   response  = '0;
    logic       busy      = 1'b0;             // Counting wait states
    logic [1:0] waitCount = '0;
    integer     seed      = 32'h84a09e2b;
    integer     rnd;

    assign wbIn = response;

    // ========================================
    // Single transfer with registered ack
    // ========================================
    task automatic acknowledge();
        if (wbOut.we) begin
            mem[wbOut.adr] <= wbOut.datW;
        end else begin
            response.datR <= mem[wbOut.adr];
        end
        response.ack <= 1'b1;
    endtask

    always @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            response  <= '0;
            busy      <= 1'b0;
            waitCount <= '0;
            mem       <= image;               // Program loaded while in reset
        end else begin
            response.ack <= 1'b0;             // One ack per transfer
            if (wbOut.stb && !response.ack) begin
                if (!busy) begin
                    rnd = $random(seed);
                    if (rnd[1:0] == 2'd0) begin
                        acknowledge();
                    end else begin
                        busy      <= 1'b1;
                        waitCount <= rnd[1:0] - 2'd1;
                    end
                end else if (waitCount == 2'd0) begin
                    acknowledge();
                    busy <= 1'b0;
                end else begin
                    waitCount <= waitCount - 2'd1;
                end
            end
        end
    end

endmodule

/* hdl/cpuSystem.sv */
`timescale 1ns/1ps

module cpuSystem
    import cpuPkg::*;
(
    input  logic      Clock,
    input  logic      Reset,
    output wbMaster_t wbOut,
    input  wbSlave_t  wbIn
);

    busRequest_t busRequest;
    logic        busDone;
    byte_t       busReadData;
    rfCommand_t  rfCommand;
    regIndex_t   readSelect;
    word_t       registerData;
    logic        zero;

    busMaster i_busMaster (
        .Clock      (Clock),
        .Reset      (Reset),
        .busRequest (busRequest),
        .busDone    (busDone),
        .readData   (busReadData),
        .wbOut      (wbOut),
        .wbIn       (wbIn)
    );

    registerFile i_registerFile (
        .Clock      (Clock),
        .Reset      (Reset),
        .rfCommand  (rfCommand),
        .readSelect (readSelect),
        .readData   (registerData),
        .zero       (zero)
    );

    controlSequencer i_controlSequencer (
        .Clock        (Clock),
        .Reset        (Reset),
        .busRequest   (busRequest),
        .busDone      (busDone),
        .readData     (busReadData),
        .rfCommand    (rfCommand),
        .readSelect   (readSelect),
        .registerData (registerData),
        .zero         (zero)
    );

endmodule

/* hdl/controlSequencer.sv */
`timescale 1ns/1ps

module controlSequencer
    import cpuPkg::*;
(
    input  logic        Clock,
    input  logic        Reset,
    output busRequest_t busRequest,
    input  logic        busDone,
    input  byte_t       readData,
    output rfCommand_t  rfCommand,
    output regIndex_t   readSelect,
    input  word_t       registerData,
    input  logic        zero
);

    phase_t    phase;
    byte_t     pc;
    byte_t     ar;
    word_t     instr;
    byte_t     loadLow;                       // First byte of an LDAL word
    opcode_t   opcode;
    regIndex_t regSel;
    byte_t     field;
    logic      branchTaken;

    assign opcode = instr[15:10];
    assign regSel = instr[9:8];
    assign field  = instr[7:0];

    always_comb begin
        case (opcode)
            OpBra:   branchTaken = 1'b1;
            OpBne:   branchTaken = !zero;
            OpBeq:   branchTaken = zero;
            default: branchTaken = 1'b0;
        endcase
    end

    // ========================================
    // Phase machine and PC
    // ========================================
    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            phase <= phFetchLow;
            pc    <= ResetPc;
        end else begin
            case (phase)
                phFetchLow: begin
                    if (busDone) begin
                        pc    <= pc + 8'd1;
                        phase <= phFetchHigh;
                    end
                end
                phFetchHigh: begin
                    if (busDone) begin
                        pc    <= pc + 8'd1;
                        phase <= phDecode;
                    end
                end
                phDecode: phase <= phExecute;
                phExecute: begin
                    if (branchTaken) begin
                        pc <= field;
                    end
                    if (opcode == OpLdal) begin
                        phase <= phLoadLow;
                    end else if (opcode == OpSta) begin
                        phase <= phStoreLow;
                    end else begin
                        phase <= phFetchLow;  // Unknown opcodes end here too
                    end
                end
                phLoadLow:   if (busDone) phase <= phLoadHigh;
                phLoadHigh:  if (busDone) phase <= phFetchLow;
                phStoreLow:  if (busDone) phase <= phStoreHigh;
                phStoreHigh: if (busDone) phase <= phFetchLow;
                default: phase <= phFetchLow;
            endcase
        end
    end

    // Instruction, address and load buffer
    always_ff @(posedge Clock) begin
        if (phase == phFetchLow && busDone) begin
            instr[7:0] <= readData;
        end
        if (phase == phFetchHigh && busDone) begin
            instr[15:8] <= readData;
        end
        if (phase == phExecute) begin
            ar <= field;                      // Only LDAL and STA read it later
        end
        if ((phase == phLoadLow || phase == phStoreLow) && busDone) begin
            ar <= ar + 8'd1;
        end
        if (phase == phLoadLow && busDone) begin
            loadLow <= readData;
        end
    end

    // ========================================
    // Command generation
    // ========================================
    assign readSelect = regSel;

    always_comb begin
        busRequest     = '0;
        rfCommand.op   = rfNone;
        rfCommand.target = regSel;
        rfCommand.data = {8'h00, field};
        case (phase)
            phFetchLow, phFetchHigh: begin
                busRequest.valid   = 1'b1;
                busRequest.address = pc;
            end
            phLoadLow: begin
                busRequest.valid   = 1'b1;
                busRequest.address = ar;
            end
            phLoadHigh: begin
                busRequest.valid   = 1'b1;
                busRequest.address = ar;
                if (busDone) begin
                    rfCommand.op   = rfLoadWord;
                    rfCommand.data = {readData, loadLow};   // Little-endian word
                end
            end
            phStoreLow, phStoreHigh: begin
                busRequest.valid   = 1'b1;
                busRequest.write   = 1'b1;
                busRequest.address = ar;
                busRequest.data    = (phase == phStoreLow) ? registerData[7:0]
                                                           : registerData[15:8];
            end
            phExecute: begin
                case (opcode)
                    OpInc:   rfCommand.op = rfIncrement;
                    OpDec:   rfCommand.op = rfDecrement;
                    OpMovl:  rfCommand.op = rfLoadLow;
                    OpMovsh: rfCommand.op = rfShiftLoad;
                    default: rfCommand.op = rfNone;
                endcase
            end
            default: ;
        endcase
    end

    // Request held steady until the bus master reports it done
    assert property (@(posedge Clock) disable iff (Reset)
        (busRequest.valid && !busDone) |=> $stable(busRequest));

endmodule

/* hdl/registerFile.sv */
`timescale 1ns/1ps

module registerFile
    import cpuPkg::*;
(
    input  logic       Clock,
    input  logic       Reset,
    input  rfCommand_t rfCommand,
    input  regIndex_t  readSelect,
    output word_t      readData,
    output logic       zero
);

    word_t regs [4];
    word_t current;
    word_t stepped;

    // ========================================
    // Update functions
    // ========================================
    assign current = regs[rfCommand.target];

    always_comb begin
        if (rfCommand.op == rfDecrement) begin
            stepped = current - 16'd1;        // Wraps at zero
        end else begin
            stepped = current + 16'd1;
        end
    end

    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            regs <= '{default: '0};
            zero <= 1'b0;
        end else begin
            case (rfCommand.op)
                rfLoadLow: begin
                    regs[rfCommand.target] <= {8'h00, rfCommand.data[7:0]};
                end
                rfShiftLoad: begin
                    regs[rfCommand.target] <= {current[7:0], rfCommand.data[7:0]};
                end
                rfLoadWord: begin
                    regs[rfCommand.target] <= rfCommand.data;
                end
                rfIncrement, rfDecrement: begin
                    regs[rfCommand.target] <= stepped;
                    zero <= (stepped == 16'h0000);   // Only INC and DEC touch Z
                end
                default: ;
            endcase
        end
    end

    assign readData = regs[readSelect];

    // Commands come from the sequencer and must decode to a real operation
    assert property (@(posedge Clock) disable iff (Reset)
        rfCommand.op inside {rfNone, rfLoadLow, rfShiftLoad, rfLoadWord,
                             rfIncrement, rfDecrement});

endmodule

/* hdl/busMaster.sv */
`timescale 1ns/1ps

module busMaster
    import cpuPkg::*;
(
    input  logic        Clock,
    input  logic        Reset,
    input  busRequest_t busRequest,
    output logic        busDone,
    output byte_t       readData,
    output wbMaster_t   wbOut,
    input  wbSlave_t    wbIn
);

    typedef enum logic {stIdle, stActive} state_t;

    state_t state;

    // ========================================
    // Transfer engine
    // ========================================
    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            state   <= stIdle;
            wbOut   <= '0;
            busDone <= 1'b0;
        end else begin
            busDone <= 1'b0;                  // Single-cycle pulse
            case (state)
                stIdle: begin
                    // A request still shown during the busDone cycle is the old one
                    if (busRequest.valid && !busDone) begin
                        wbOut <= '{cyc: 1'b1, stb: 1'b1, we: busRequest.write,
                                   adr: busRequest.address, datW: busRequest.data};
                        state <= stActive;
                    end
                end
                stActive: begin
                    if (wbIn.ack) begin
                        wbOut.cyc <= 1'b0;
                        wbOut.stb <= 1'b0;
                        wbOut.we  <= 1'b0;
                        busDone   <= 1'b1;
                        state     <= stIdle;
                    end
                end
                default: state <= stIdle;
            endcase
        end
    end

    always_ff @(posedge Clock) begin
        if (state == stActive && wbIn.ack) begin
            readData <= wbIn.datR;            // Valid while busDone is high
        end
    end

    // Cycle held with fixed address until the slave answers
    assert property (@(posedge Clock) disable iff (Reset)
        (wbOut.stb && !wbIn.ack) |=> (wbOut.stb && $stable(wbOut.adr)));

    assert property (@(posedge Clock) disable iff (Reset) wbOut.cyc == wbOut.stb);

endmodule

/* hdl/cpuPkg.sv */
package cpuPkg;

    // ========================================
    // Widths
    // ========================================
    typedef logic [7:0]  byte_t;              // Memory byte, PC, AR, immediate
    typedef logic [15:0] word_t;              // Register value, instruction
    typedef logic [1:0]  regIndex_t;          // R0 to R3
    typedef logic [5:0]  opcode_t;            // Instruction bits 15 to 10

    localparam byte_t ResetPc = 8'h00;        // First fetch address

    // ========================================
    // Opcodes
    // ========================================
    localparam opcode_t OpBra   = 6'h00;
    localparam opcode_t OpBne   = 6'h01;
    localparam opcode_t OpBeq   = 6'h02;
    localparam opcode_t OpInc   = 6'h09;
    localparam opcode_t OpDec   = 6'h0A;
    localparam opcode_t OpMovl  = 6'h19;      // Immediate into low byte
    localparam opcode_t OpMovsh = 6'h1A;      // Shift low byte up, then load
    localparam opcode_t OpLdal  = 6'h1E;
    localparam opcode_t OpSta   = 6'h20;

    // ========================================
    // Enums and bundles
    // ========================================
    typedef enum logic [2:0] {
        phFetchLow, phFetchHigh, phDecode, phExecute,
        phLoadLow, phLoadHigh, phStoreLow, phStoreHigh
    } phase_t;

    typedef enum logic [2:0] {
        rfNone, rfLoadLow, rfShiftLoad, rfLoadWord, rfIncrement, rfDecrement
    } rfOp_t;

    typedef struct packed {
        rfOp_t     op;
        regIndex_t target;
        word_t     data;
    } rfCommand_t;                            // 21 bits

    typedef struct packed {
        logic  valid;
        logic  write;
        byte_t address;
        byte_t data;
    } busRequest_t;                           // 18 bits

    typedef struct packed {
        logic  cyc;
        logic  stb;
        logic  we;
        byte_t adr;
        byte_t datW;
    } wbMaster_t;                             // 19 bits

    typedef struct packed {
        logic  ack;
        byte_t datR;
    } wbSlave_t;                              // 9 bits

endpackage
